/* vlog.f */
rtl/lsu_pkg.sv
rtl/lsu_ctrl.sv
rtl/lsu_req_gen.sv
rtl/lsu_rdata_align.sv
rtl/lsu_top.sv
dv/tb_clk_gen.sv
dv/tb_mem_model.sv
dv/tb_lsu.sv

/* dv/tb_lsu.sv */
`timescale 1ns/100ps
// testbench for the load/store unit
// random loads and stores checked against a byte-array reference model,
// plus bus protocol monitoring
module tb_lsu;

  localparam int unsigned NumOps      = 300;
  localparam int unsigned MemBytes    = 256;
  // upper 16 bytes of the window answer with a bus error
  localparam int unsigned ErrBase     = MemBytes - 16;
  localparam int          ClkPeriodNs = 4;
  localparam int          Seed        = 32'h6de7;

  logic                          clk;
  logic                          rst_n;
  logic                          lsu_req, lsu_we, lsu_sign_ext;
  lsu_pkg::lsu_type_e            lsu_type;
  logic [lsu_pkg::DataWidth-1:0] lsu_addr, lsu_wdata, lsu_rdata, addr_last;
  logic                          lsu_req_done, lsu_resp_valid, lsu_rdata_valid;
  logic                          load_err, store_err, busy;
  logic                          data_req, data_gnt, data_rvalid, data_bus_err, data_we;
  logic [lsu_pkg::DataWidth-1:0] data_addr, data_wdata, data_rdata;
  logic [lsu_pkg::BeWidth-1:0]   data_be;

  integer      seed;
  int unsigned value_errs;
  int unsigned proto_errs;
  logic [7:0]  ref_mem [MemBytes];

  // grants and strobes seen during the current access
  logic [lsu_pkg::DataWidth-1:0] gnt_addr [$];
  logic [lsu_pkg::DataWidth-1:0] gnt_wdata [$];
  logic [lsu_pkg::BeWidth-1:0]   gnt_be [$];
  logic                          gnt_we [$];
  int unsigned                   done_cnt;
  int unsigned                   resp_cnt;
  int                            outstanding;
  // request state of the previous cycle for the hold check
  logic                          stall_q;
  logic [lsu_pkg::DataWidth-1:0] hold_addr, hold_wdata;
  logic [lsu_pkg::BeWidth-1:0]   hold_be;
  logic                          hold_we;

  tb_clk_gen #(.PeriodNs(ClkPeriodNs), .ResetCycles(2)) u_clk (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tb_mem_model #(.MemBytes(MemBytes), .ErrBase(ErrBase), .Seed(Seed)) u_mem (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .data_req_i     (data_req),
    .data_addr_i    (data_addr),
    .data_we_i      (data_we),
    .data_be_i      (data_be),
    .data_wdata_i   (data_wdata),
    .data_gnt_o     (data_gnt),
    .data_rvalid_o  (data_rvalid),
    .data_rdata_o   (data_rdata),
    .data_bus_err_o (data_bus_err)
  );

  lsu_top dut (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .lsu_req_i         (lsu_req),
    .lsu_we_i          (lsu_we),
    .lsu_type_i        (lsu_type),
    .lsu_sign_ext_i    (lsu_sign_ext),
    .lsu_addr_i        (lsu_addr),
    .lsu_wdata_i       (lsu_wdata),
    .lsu_req_done_o    (lsu_req_done),
    .lsu_resp_valid_o  (lsu_resp_valid),
    .lsu_rdata_valid_o (lsu_rdata_valid),
    .lsu_rdata_o       (lsu_rdata),
    .load_err_o        (load_err),
    .store_err_o       (store_err),
    .busy_o            (busy),
    .addr_last_o       (addr_last),
    .data_req_o        (data_req),
    .data_gnt_i        (data_gnt),
    .data_rvalid_i     (data_rvalid),
    .data_bus_err_i    (data_bus_err),
    .data_addr_o       (data_addr),
    .data_we_o         (data_we),
    .data_be_o         (data_be),
    .data_wdata_o      (data_wdata),
    .data_rdata_i      (data_rdata)
  );

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      value_errs++;
      $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_protocol(input string msg);
    proto_errs++;
    $display("%0t: protocol error, %s", $time, msg);
  endtask

  function automatic lsu_pkg::lsu_type_e pick_type(input logic [31:0] r);
    case (r % 3)
      0:       return lsu_pkg::TYPE_WORD;
      1:       return lsu_pkg::TYPE_HALF;
      default: return lsu_pkg::TYPE_BYTE;
    endcase
  endfunction

  //////////////////////////////
  // bus monitor
  //////////////////////////////

  // mid-cycle sampling, all inputs settled
  always @(negedge clk) begin : bus_monitor
    if (rst_n) begin
      if (stall_q && (!data_req || data_addr !== hold_addr || data_be !== hold_be ||
                      data_we !== hold_we || data_wdata !== hold_wdata)) begin
        report_protocol("request dropped or changed while waiting for grant");
      end
      if (data_req && data_addr[1:0] != 2'b00) begin
        report_protocol("bus address is not word aligned");
      end
      if (lsu_req_done && !(data_req && data_gnt)) begin
        report_protocol("request done raised without a grant");
      end
      if (data_req && data_gnt) begin
        gnt_addr.push_back(data_addr);
        gnt_wdata.push_back(data_wdata);
        gnt_be.push_back(data_be);
        gnt_we.push_back(data_we);
        outstanding++;
      end
      if (data_rvalid) begin
        outstanding--;
      end
      if (outstanding > 2 || outstanding < 0) begin
        report_protocol("outstanding request count out of range");
      end
      done_cnt += lsu_req_done;
      resp_cnt += lsu_resp_valid;
      stall_q    = data_req && !data_gnt;
      hold_addr  = data_addr;
      hold_wdata = data_wdata;
      hold_be    = data_be;
      hold_we    = data_we;
    end else begin
      stall_q     = 1'b0;
      outstanding = 0;
    end
  end

  //////////////////////////////
  // one access
  //////////////////////////////

  // starts at a rising edge, ends at a rising edge
  task automatic run_access(input int unsigned idx);
    logic [31:0]                   r;
    logic                          we, sext, split, err0, err1, exp_err;
    lsu_pkg::lsu_type_e            ty;
    logic [lsu_pkg::DataWidth-1:0] addr, wdata, w0, exp_data, exp_last;
    logic [lsu_pkg::BeWidth-1:0]   exp_be [2];
    int unsigned                   size, ba, part, bi;
    r     = $random(seed);
    we    = r[0];
    sext  = r[1];
    ty    = pick_type(r >> 8);
    addr  = $unsigned($random(seed)) % MemBytes;
    wdata = $random(seed);
    size  = (ty == lsu_pkg::TYPE_WORD) ? 4 : (ty == lsu_pkg::TYPE_HALF) ? 2 : 1;
    w0    = addr & ~32'd3;
    split = (addr % 4) + size > 4;
    err0  = (w0 % MemBytes) >= ErrBase;
    err1  = split && (((w0 + 4) % MemBytes) >= ErrBase);
    exp_err  = err0 | err1;
    exp_last = (split && !err0) ? w0 + 4 : addr;
    // lanes per part and little-endian load value
    exp_be[0] = '0;
    exp_be[1] = '0;
    exp_data  = '0;
    for (int i = 0; i < size; i++) begin
      ba   = addr + i;
      part = (ba >> 2) != (addr >> 2);
      exp_be[part][ba % 4] = 1'b1;
      exp_data[8*i +: 8]   = ref_mem[ba % MemBytes];
    end
    if (sext && size == 2 && exp_data[15]) exp_data[31:16] = '1;
    if (sext && size == 1 && exp_data[7]) exp_data[31:8] = '1;

    gnt_addr.delete();
    gnt_wdata.delete();
    gnt_be.delete();
    gnt_we.delete();
    done_cnt = 0;
    resp_cnt = 0;
    #1;
    lsu_req      = 1'b1;
    lsu_we       = we;
    lsu_type     = ty;
    lsu_sign_ext = sext;
    lsu_addr     = addr;
    lsu_wdata    = wdata;
    do @(negedge clk); while (!lsu_req_done);
    // core moves on, leftover inputs must not matter
    @(posedge clk);
    #1;
    r            = $random(seed);
    lsu_req      = 1'b0;
    lsu_we       = r[0];
    lsu_sign_ext = r[1];
    lsu_type     = pick_type(r >> 4);
    lsu_addr     = $random(seed);
    lsu_wdata    = $random(seed);
    do @(negedge clk); while (!lsu_resp_valid);

    check_value(load_err, !we && exp_err, $sformatf("op %0d load error", idx));
    check_value(store_err, we && exp_err, $sformatf("op %0d store error", idx));
    check_value(lsu_rdata_valid, !we && !exp_err, $sformatf("op %0d rdata valid", idx));
    if (!we && !exp_err) begin
      check_value(lsu_rdata, exp_data, $sformatf("op %0d load data at %h", idx, addr));
    end
    check_value(addr_last, exp_last, $sformatf("op %0d last address", idx));
    // model write skips parts that hit the error region
    if (we) begin
      for (int i = 0; i < size; i++) begin
        ba   = addr + i;
        part = (ba >> 2) != (addr >> 2);
        if (!(part ? err1 : err0)) begin
          ref_mem[ba % MemBytes] = wdata[8*i +: 8];
        end
      end
    end
    @(negedge clk);
    check_value(busy, 1'b0, $sformatf("op %0d busy while idle", idx));
    @(posedge clk);
    check_value(done_cnt, 1, $sformatf("op %0d done strobes", idx));
    check_value(resp_cnt, 1, $sformatf("op %0d response strobes", idx));
    check_value(gnt_addr.size(), split ? 2 : 1, $sformatf("op %0d granted requests", idx));
    for (int p = 0; p < gnt_addr.size() && p < 2; p++) begin
      check_value(gnt_addr[p], w0 + 4 * p, $sformatf("op %0d part %0d address", idx, p));
      check_value(gnt_be[p], exp_be[p], $sformatf("op %0d part %0d byte enables", idx, p));
      check_value(gnt_we[p], we, $sformatf("op %0d part %0d write enable", idx, p));
      for (int l = 0; l < lsu_pkg::BeWidth; l++) begin
        if (we && exp_be[p][l]) begin
          bi = w0 + 4 * p + l - addr;
          check_value(gnt_wdata[p][8*l +: 8], wdata[8*bi +: 8],
                      $sformatf("op %0d part %0d store lane %0d", idx, p, l));
        end
      end
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin : stimulus
    seed         = Seed;
    value_errs   = 0;
    proto_errs   = 0;
    outstanding  = 0;
    stall_q      = 1'b0;
    lsu_req      = 1'b0;
    lsu_we       = 1'b0;
    lsu_type     = lsu_pkg::TYPE_WORD;
    lsu_sign_ext = 1'b0;
    lsu_addr     = '0;
    lsu_wdata    = '0;
    @(posedge rst_n);
    // reference starts from the memory fill
    for (int i = 0; i < MemBytes; i++) begin
      ref_mem[i] = u_mem.mem[i];
    end
    @(negedge clk);
    check_value(data_req, 1'b0, "data_req after reset");
    check_value(lsu_req_done, 1'b0, "req_done after reset");
    check_value(lsu_resp_valid, 1'b0, "resp_valid after reset");
    check_value(lsu_rdata_valid, 1'b0, "rdata_valid after reset");
    check_value(load_err, 1'b0, "load_err after reset");
    check_value(store_err, 1'b0, "store_err after reset");
    check_value(busy, 1'b0, "busy after reset");
    check_value(addr_last, '0, "addr_last after reset");
    @(posedge clk);
    for (int op = 0; op < NumOps; op++) begin
      run_access(op);
    end
    $display("run ended: %0d value errors, %0d protocol errors", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // about 20 cycles per access is far above the worst memory delay
  initial begin : watchdog
    #(NumOps * 20 * ClkPeriodNs);
    $display("watchdog expired, the accesses did not complete in time");
    $display("TB FAILED");
    $finish;
  end

endmodule

/* dv/tb_mem_model.sv */
`timescale 1ns/100ps
// behavioral byte memory behind a word bus
// random grant, in-order responses after 1 to 3 cycles,
// words at or above ErrBase answer with a bus error and ignore writes
module tb_mem_model #(
  parameter int unsigned MemBytes = 256,
  parameter int unsigned ErrBase  = 240,
  parameter int          Seed     = 1
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            data_req_i,
  input  logic [lsu_pkg::DataWidth-1:0]   data_addr_i,
  input  logic                            data_we_i,
  input  logic [lsu_pkg::BeWidth-1:0]     data_be_i,
  input  logic [lsu_pkg::DataWidth-1:0]   data_wdata_i,
  output logic                            data_gnt_o,
  output logic                            data_rvalid_o,
  output logic [lsu_pkg::DataWidth-1:0]   data_rdata_o,
  output logic                            data_bus_err_o
);

  logic [7:0]                  mem [MemBytes];
  integer                      seed;
  logic                        gnt_en;
  int unsigned                 cyc;
  int unsigned                 last_due;
  // responses waiting to go out, oldest first
  logic [lsu_pkg::DataWidth-1:0] rsp_data [$];
  logic                          rsp_err [$];
  int unsigned                   rsp_due [$];

  initial begin
    seed           = Seed;
    gnt_en         = 1'b0;
    data_rvalid_o  = 1'b0;
    data_rdata_o   = '0;
    data_bus_err_o = 1'b0;
    cyc            = 0;
    last_due       = 0;
    // odd multiplier keeps every byte address distinct
    for (int i = 0; i < MemBytes; i++) begin
      mem[i] = 8'(i * 37 + 11);
    end
  end

  assign data_gnt_o = data_req_i & gnt_en;

  always @(posedge clk_i) begin : mem_seq
    logic [lsu_pkg::DataWidth-1:0] word;
    logic [31:0]                   r;
    int unsigned                   base;
    int unsigned                   due;
    logic                          err;
    cyc++;
    if (!rst_ni) begin
      rsp_data.delete();
      rsp_err.delete();
      rsp_due.delete();
      last_due = 0;
    end else if (data_req_i && data_gnt_o) begin
      base = (data_addr_i % MemBytes) & ~32'd3;
      err  = base >= ErrBase;
      word = '0;
      for (int l = 0; l < lsu_pkg::BeWidth; l++) begin
        if (data_we_i && data_be_i[l] && !err) begin
          mem[base + l] = data_wdata_i[8*l +: 8];
        end
        word[8*l +: 8] = mem[base + l];
      end
      r   = $random(seed);
      due = cyc + (r % 3);
      // keep order, one response per cycle
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      rsp_data.push_back(err ? '0 : word);
      rsp_err.push_back(err);
      rsp_due.push_back(due);
    end
    #1;
    data_rvalid_o  = 1'b0;
    data_rdata_o   = '0;
    data_bus_err_o = 1'b0;
    if (rsp_due.size() > 0 && rsp_due[0] <= cyc) begin
      data_rvalid_o  = 1'b1;
      data_rdata_o   = rsp_data.pop_front();
      data_bus_err_o = rsp_err.pop_front();
      void'(rsp_due.pop_front());
    end
    // grant coin for the next cycle
    r      = $random(seed);
    gnt_en = r[0];
  end

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/100ps
// clock and reset source for the testbench
module tb_clk_gen #(
  parameter int PeriodNs    = 4,
  parameter int ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // release reset just after an edge, away from the sampling point
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

/* rtl/lsu_top.sv */
`timescale 1ns/100ps
// load/store unit top level
// control FSM plus request and response datapaths
module lsu_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // core side
  input  logic                          lsu_req_i,
  input  logic                          lsu_we_i,
  input  lsu_pkg::lsu_type_e            lsu_type_i,
  input  logic                          lsu_sign_ext_i,
  input  logic [lsu_pkg::DataWidth-1:0] lsu_addr_i,
  input  logic [lsu_pkg::DataWidth-1:0] lsu_wdata_i,
  output logic                          lsu_req_done_o,
  output logic                          lsu_resp_valid_o,
  output logic                          lsu_rdata_valid_o,
  output logic [lsu_pkg::DataWidth-1:0] lsu_rdata_o,
  output logic                          load_err_o,
  output logic                          store_err_o,
  output logic                          busy_o,
  output logic [lsu_pkg::DataWidth-1:0] addr_last_o,
  // memory side
  output logic                          data_req_o,
  input  logic                          data_gnt_i,
  input  logic                          data_rvalid_i,
  input  logic                          data_bus_err_i,
  output logic [lsu_pkg::DataWidth-1:0] data_addr_o,
  output logic                          data_we_o,
  output logic [lsu_pkg::BeWidth-1:0]   data_be_o,
  output logic [lsu_pkg::DataWidth-1:0] data_wdata_o,
  input  logic [lsu_pkg::DataWidth-1:0] data_rdata_i
);

  logic                            second_part;
  logic                            addr_update;
  logic                            ctrl_update;
  logic                            rdata_update;
  logic                            split_access;
  logic                            we_q;
  logic [lsu_pkg::OffsetWidth-1:0] offset;

  lsu_ctrl u_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .split_access_i    (split_access),
    .we_q_i            (we_q),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_bus_err_i    (data_bus_err_i),
    .data_req_o        (data_req_o),
    .second_part_o     (second_part),
    .addr_update_o     (addr_update),
    .ctrl_update_o     (ctrl_update),
    .rdata_update_o    (rdata_update),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o)
  );

  lsu_req_gen u_req_gen (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsu_addr_i     (lsu_addr_i),
    .lsu_type_i     (lsu_type_i),
    .lsu_we_i       (lsu_we_i),
    .lsu_wdata_i    (lsu_wdata_i),
    .second_part_i  (second_part),
    .addr_update_i  (addr_update),
    .split_access_o (split_access),
    .we_q_o         (we_q),
    .offset_o       (offset),
    .data_addr_o    (data_addr_o),
    .data_we_o      (data_we_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o),
    .addr_last_o    (addr_last_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .offset_i       (offset),
    .lsu_type_i     (lsu_type_i),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .data_rdata_i   (data_rdata_i),
    .lsu_rdata_o    (lsu_rdata_o)
  );

endmodule

/* rtl/lsu_rdata_align.sv */
`timescale 1ns/100ps
// response datapath of the load/store unit
// keeps the access attributes and the first response word of a split load,
// then realigns and extends the loaded field
module lsu_rdata_align (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            ctrl_update_i,
  input  logic                            rdata_update_i,
  input  logic [lsu_pkg::OffsetWidth-1:0] offset_i,
  input  lsu_pkg::lsu_type_e              lsu_type_i,
  input  logic                            lsu_sign_ext_i,
  input  logic [lsu_pkg::DataWidth-1:0]   data_rdata_i,
  output logic [lsu_pkg::DataWidth-1:0]   lsu_rdata_o
);

  localparam int unsigned ByteW = 8;
  localparam int unsigned HalfW = lsu_pkg::DataWidth / 2;

  logic [lsu_pkg::OffsetWidth-1:0]       offset_q;
  lsu_pkg::lsu_type_e                    type_q;
  logic                                  sign_ext_q;
  // upper three bytes of the first response word
  logic [lsu_pkg::DataWidth-1:ByteW]     rdata_q;
  logic [2*lsu_pkg::DataWidth-ByteW-1:0] rdata_cat;
  logic [lsu_pkg::DataWidth-1:0]         word_sel;
  logic [HalfW-1:0]                      half_sel;
  logic [ByteW-1:0]                      byte_sel;

  //////////////////////////////
  // captured state
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= '0;
      type_q     <= lsu_pkg::TYPE_WORD;
      sign_ext_q <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q   <= offset_i;
      type_q     <= lsu_type_i;
      sign_ext_q <= lsu_sign_ext_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= data_rdata_i[lsu_pkg::DataWidth-1:ByteW];
    end
  end

  //////////////////////////////
  // realignment
  //////////////////////////////

  // saved bytes sit below the current response,
  // a split field starts offset-1 bytes into this string
  assign rdata_cat = {data_rdata_i, rdata_q};

  always_comb begin
    if (offset_q == '0) begin
      word_sel = data_rdata_i;
    end else begin
      word_sel = rdata_cat[{offset_q - 2'd1, 3'b000} +: lsu_pkg::DataWidth];
    end
  end

  always_comb begin
    unique case (offset_q)
      2'd0:    half_sel = data_rdata_i[15:0];
      2'd1:    half_sel = data_rdata_i[23:8];
      2'd2:    half_sel = data_rdata_i[31:16];
      default: half_sel = {data_rdata_i[7:0], rdata_q[31:24]};
    endcase
  end

  // a byte never crosses a word
  assign byte_sel = data_rdata_i[{offset_q, 3'b000} +: ByteW];

  //////////////////////////////
  // extension
  //////////////////////////////

  // top bit of the field fills the upper bits on signed loads
  always_comb begin
    unique case (type_q)
      lsu_pkg::TYPE_WORD: begin
        lsu_rdata_o = word_sel;
      end
      lsu_pkg::TYPE_HALF: begin
        lsu_rdata_o = {{(lsu_pkg::DataWidth - HalfW){sign_ext_q & half_sel[HalfW-1]}},
                       half_sel};
      end
      default: begin
        lsu_rdata_o = {{(lsu_pkg::DataWidth - ByteW){sign_ext_q & byte_sel[ByteW-1]}},
                       byte_sel};
      end
    endcase
  end

  // captured size must be a driven value from the core
  a_type_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(type_q));

endmodule

/* rtl/lsu_req_gen.sv */
`timescale 1ns/100ps
// request datapath of the load/store unit
// word-aligned bus address, byte enables and lane-rotated store data,
// plus the last access address kept for trap reporting
module lsu_req_gen (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [lsu_pkg::DataWidth-1:0]   lsu_addr_i,
  input  lsu_pkg::lsu_type_e              lsu_type_i,
  input  logic                            lsu_we_i,
  input  logic [lsu_pkg::DataWidth-1:0]   lsu_wdata_i,
  input  logic                            second_part_i,
  input  logic                            addr_update_i,
  output logic                            split_access_o,
  output logic                            we_q_o,
  output logic [lsu_pkg::OffsetWidth-1:0] offset_o,
  output logic [lsu_pkg::DataWidth-1:0]   data_addr_o,
  output logic                            data_we_o,
  output logic [lsu_pkg::BeWidth-1:0]     data_be_o,
  output logic [lsu_pkg::DataWidth-1:0]   data_wdata_o,
  output logic [lsu_pkg::DataWidth-1:0]   addr_last_o
);

  // word index bits of a byte address
  localparam int unsigned WordIdxW = lsu_pkg::DataWidth - lsu_pkg::OffsetWidth;
  // select width into the doubled store word
  localparam int unsigned RotW = $clog2(2 * lsu_pkg::DataWidth);

  logic [lsu_pkg::OffsetWidth-1:0]   offset;
  logic [WordIdxW-1:0]               word_idx;
  logic [2*lsu_pkg::DataWidth-1:0]   wdata_dbl;
  logic [RotW-1:0]                   rot_lo;
  logic [lsu_pkg::DataWidth-1:0]     addr_last_q, addr_last_d;
  logic                              we_q;

  assign offset   = lsu_addr_i[lsu_pkg::OffsetWidth-1:0];
  assign offset_o = offset;

  // word access off alignment, or half-word crossing into the next word
  assign split_access_o =
      ((lsu_type_i == lsu_pkg::TYPE_WORD) && (offset != '0)) ||
      ((lsu_type_i == lsu_pkg::TYPE_HALF) && (offset == '1));

  //////////////////////////////
  // address
  //////////////////////////////

  // second part targets the following word
  assign word_idx    = lsu_addr_i[lsu_pkg::DataWidth-1:lsu_pkg::OffsetWidth] +
                       WordIdxW'(second_part_i);
  assign data_addr_o = {word_idx, {lsu_pkg::OffsetWidth{1'b0}}};
  assign data_we_o   = lsu_we_i;

  //////////////////////////////
  // byte enables
  //////////////////////////////

  always_comb begin
    unique case (lsu_type_i)
      lsu_pkg::TYPE_WORD: begin
        // first part covers offset upwards and the second part the lanes below
        if (second_part_i) begin
          data_be_o = ~({lsu_pkg::BeWidth{1'b1}} << offset);
        end else begin
          data_be_o = {lsu_pkg::BeWidth{1'b1}} << offset;
        end
      end
      lsu_pkg::TYPE_HALF: begin
        // only offset 3 has a second part and it is lane 0
        if (second_part_i) begin
          data_be_o = lsu_pkg::BeWidth'(1);
        end else begin
          data_be_o = lsu_pkg::BeWidth'(2'b11) << offset;
        end
      end
      default: begin
        data_be_o = lsu_pkg::BeWidth'(1) << offset;
      end
    endcase
  end

  //////////////////////////////
  // store data
  //////////////////////////////

  // rotate left by offset bytes as one window into two copies of the word
  assign wdata_dbl    = {lsu_wdata_i, lsu_wdata_i};
  assign rot_lo       = RotW'(lsu_pkg::DataWidth) - RotW'({offset, 3'b000});
  assign data_wdata_o = wdata_dbl[rot_lo +: lsu_pkg::DataWidth];

  //////////////////////////////
  // last address and we
  //////////////////////////////

  // second part address comes from the registered first-part address
  // because the core may already have moved on once both parts are granted
  assign addr_last_d = second_part_i ?
      {addr_last_q[lsu_pkg::DataWidth-1:lsu_pkg::OffsetWidth] + WordIdxW'(1),
       {lsu_pkg::OffsetWidth{1'b0}}} :
      lsu_addr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
      we_q        <= 1'b0;
    end else if (addr_update_i) begin
      addr_last_q <= addr_last_d;
      // direction is taken with the first grant only
      if (!second_part_i) begin
        we_q <= lsu_we_i;
      end
    end
  end

  assign addr_last_o = addr_last_q;
  assign we_q_o      = we_q;

  // bus address never carries a byte offset
  a_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_addr_o[lsu_pkg::OffsetWidth-1:0] == '0);

endmodule

/* rtl/lsu_ctrl.sv */
`timescale 1ns/100ps
// load/store unit control
// issues one or two grant-gated bus requests per access and
// raises the done, response and error strobes towards the core
module lsu_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic lsu_req_i,
  input  logic split_access_i,
  input  logic we_q_i,
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  input  logic data_bus_err_i,
  output logic data_req_o,
  output logic second_part_o,
  output logic addr_update_o,
  output logic ctrl_update_o,
  output logic rdata_update_o,
  output logic lsu_req_done_o,
  output logic lsu_resp_valid_o,
  output logic lsu_rdata_valid_o,
  output logic load_err_o,
  output logic store_err_o,
  output logic busy_o
);

  lsu_pkg::ls_fsm_e state_q, state_d;
  // bus error seen on the first part of a split access
  logic err_q, err_d;
  // final response of the last access not yet returned
  logic pend_q, pend_d;
  logic can_issue;
  logic any_err;

  // a new access may only start once the previous final response is in,
  // which keeps rvalid ordering unambiguous and caps outstanding requests at two
  assign can_issue = ~pend_q | data_rvalid_i;

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    state_d        = state_q;
    err_d          = err_q;
    data_req_o     = 1'b0;
    second_part_o  = 1'b0;
    addr_update_o  = 1'b0;
    ctrl_update_o  = 1'b0;
    rdata_update_o = 1'b0;
    lsu_req_done_o = 1'b0;

    unique case (state_q)
      lsu_pkg::IDLE: begin
        if (lsu_req_i && can_issue) begin
          data_req_o = 1'b1;
          err_d      = 1'b0;
          if (data_gnt_i) begin
            ctrl_update_o  = 1'b1;
            addr_update_o  = 1'b1;
            // aligned access is complete on its only grant
            lsu_req_done_o = ~split_access_i;
            state_d = split_access_i ? lsu_pkg::WAIT_RVALID_MIS : lsu_pkg::IDLE;
          end else begin
            state_d = split_access_i ? lsu_pkg::WAIT_GNT_MIS : lsu_pkg::WAIT_GNT;
          end
        end
      end

      lsu_pkg::WAIT_GNT_MIS: begin
        // first part still waiting for the bus
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update_o = 1'b1;
          state_d       = lsu_pkg::WAIT_RVALID_MIS;
        end
      end

      lsu_pkg::WAIT_RVALID_MIS: begin
        // second part goes out while the first response is pending
        data_req_o    = 1'b1;
        second_part_o = 1'b1;
        if (data_rvalid_i) begin
          err_d          = data_bus_err_i;
          rdata_update_o = ~we_q_i;
          if (data_gnt_i) begin
            // keep the first failing address
            addr_update_o  = ~data_bus_err_i;
            lsu_req_done_o = 1'b1;
            state_d        = lsu_pkg::IDLE;
          end else begin
            state_d = lsu_pkg::WAIT_GNT;
          end
        end else if (data_gnt_i) begin
          lsu_req_done_o = 1'b1;
          state_d        = lsu_pkg::WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      lsu_pkg::WAIT_GNT: begin
        // either an aligned access or the second part of a split one,
        // the core still holds its inputs here
        data_req_o    = 1'b1;
        second_part_o = split_access_i;
        if (data_gnt_i) begin
          ctrl_update_o  = 1'b1;
          addr_update_o  = ~err_q;
          lsu_req_done_o = 1'b1;
          state_d        = lsu_pkg::IDLE;
        end
      end

      lsu_pkg::WAIT_RVALID_MIS_GNTS_DONE: begin
        // both parts granted, first response still due
        second_part_o = 1'b1;
        if (data_rvalid_i) begin
          err_d          = data_bus_err_i;
          addr_update_o  = ~data_bus_err_i;
          rdata_update_o = ~we_q_i;
          state_d        = lsu_pkg::IDLE;
        end
      end

      default: begin
        state_d = lsu_pkg::IDLE;
      end
    endcase
  end

  // set on the final grant wins over a response in the same cycle
  always_comb begin
    pend_d = pend_q;
    if (lsu_req_done_o) begin
      pend_d = 1'b1;
    end else if (lsu_resp_valid_o) begin
      pend_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= lsu_pkg::IDLE;
      err_q   <= 1'b0;
      pend_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
      pend_q  <= pend_d;
    end
  end

  //////////////////////////////
  // response strobes
  //////////////////////////////

  // final response always lands in IDLE
  assign lsu_resp_valid_o  = (state_q == lsu_pkg::IDLE) & pend_q & data_rvalid_i;
  // merge first-part error with the current one
  assign any_err           = err_q | data_bus_err_i;
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~any_err & ~we_q_i;
  assign load_err_o        = lsu_resp_valid_o & any_err & ~we_q_i;
  assign store_err_o       = lsu_resp_valid_o & any_err & we_q_i;
  assign busy_o            = (state_q != lsu_pkg::IDLE) | pend_q;

  // state register never leaves the legal encodings
  a_state_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {lsu_pkg::IDLE, lsu_pkg::WAIT_GNT_MIS, lsu_pkg::WAIT_RVALID_MIS,
                    lsu_pkg::WAIT_GNT, lsu_pkg::WAIT_RVALID_MIS_GNTS_DONE});

  // once raised the bus request is held until the memory grants it
  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o);

endmodule

/* rtl/lsu_pkg.sv */
// shared definitions of the load/store unit
// bus widths, access size encoding and control FSM states
package lsu_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // data bus and register width, byte-lane logic assumes 32
  parameter int unsigned DataWidth = 32;
  // one enable per byte lane
  parameter int unsigned BeWidth = DataWidth / 8;
  // byte offset inside a word
  parameter int unsigned OffsetWidth = $clog2(BeWidth);

  //////////////////////////////
  // encodings
  //////////////////////////////

  // access size as given by the pipeline
  typedef enum logic [1:0] {
    TYPE_WORD = 2'b00,
    TYPE_HALF = 2'b01,
    TYPE_BYTE = 2'b10
  } lsu_type_e;

  // control FSM states
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,
    WAIT_RVALID_MIS,
    WAIT_GNT,
    WAIT_RVALID_MIS_GNTS_DONE
  } ls_fsm_e;

endpackage
